//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_cabinet_io -f build.f
	./obj_dir/Vtb_cabinet_io

clean:
	rm -rf obj_dir

//--- build.f
+incdir+include
hw/cabinet_pkg.sv
hw/cabinet_regs.sv
hw/spinner_counter.sv
hw/input_port_mux.sv
hw/cabinet_io_top.sv
tests/tb_clock_gen.sv
tests/cabinet_props.sv
tests/tb_cabinet_io.sv

//--- hw/cabinet_io_top.sv
// Player-control block of the arcade board; single clock domain, APB without wait states
`timescale 1ns/1ns
`include "cabinet_cfg.svh"

module cabinet_io_top
	import cabinet_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst,

	// APB slave
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`CAB_ADDR_W-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,

	// Controls
	input  joy_word_t              player1,
	input  joy_word_t              player2,
	input  logic                   vsync_strobe,

	// CPU input bytes
	output port_byte_t             input_0,
	output port_byte_t             input_1,
	output port_byte_t             input_2,
	output port_byte_t             input_3,
	output logic                   landscape
);

	variant_t   variant;
	port_byte_t dip0;
	port_byte_t dip1;
	spin_t      spin;

	// ====================
	// Settings and spinner
	// ====================
	cabinet_regs regs0 (
		.clk_sys (clk_sys),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.spin    (spin),
		.variant (variant),
		.dip0    (dip0),
		.dip1    (dip1)
	);

	spinner_counter spin0 (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.player1      (player1),
		.player2      (player2),
		.vsync_strobe (vsync_strobe),
		.spin         (spin)
	);

	// ====================
	// Port builder
	// ====================
	input_port_mux mux0 (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.player1   (player1),
		.player2   (player2),
		.variant   (variant),
		.dip0      (dip0),
		.dip1      (dip1),
		.spin      (spin),
		.input_0   (input_0),
		.input_1   (input_1),
		.input_2   (input_2),
		.input_3   (input_3),
		.landscape (landscape)
	);

endmodule

//--- hw/cabinet_pkg.sv
// Shared types for the cabinet input block; joystick bit order is fixed by the host controller
`include "cabinet_cfg.svh"

package cabinet_pkg;

	// ====================
	// Payload types
	// ====================

	// One player's buttons, active high
	typedef logic [`CAB_JOY_W-1:0] joy_word_t;

	// CPU input byte, active low
	typedef logic [`CAB_PORT_W-1:0] port_byte_t;

	// Rotary position
	typedef logic [`CAB_SPIN_W-1:0] spin_t;

	typedef enum logic [1:0] {
		VAR_BAR    = `CAB_VAR_BAR,
		VAR_LUMBER = `CAB_VAR_LUMBER,
		VAR_DISC   = `CAB_VAR_DISC,
		VAR_BAND   = `CAB_VAR_BAND
	} variant_t;

	// ====================
	// Joystick bit positions
	// ====================
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;
	localparam int JOY_RCW    = 8;
	localparam int JOY_RCCW   = 9;
	localparam int JOY_START  = 10;
	localparam int JOY_COIN   = 11;

endpackage

//--- hw/cabinet_regs.sv
// APB slave without wait states; only addresses 0x00-0x0C are mapped and pwdata bits above 7 are ignored
`timescale 1ns/1ns
`include "cabinet_cfg.svh"

module cabinet_regs
	import cabinet_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst,

	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`CAB_ADDR_W-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,

	input  spin_t                  spin,
	output variant_t               variant,
	output port_byte_t             dip0,
	output port_byte_t             dip1
);

	// ====================
	// Address decode
	// ====================
	logic access;
	logic hit_variant;
	logic hit_dip0;
	logic hit_dip1;
	logic hit_spin;
	logic mapped;
	logic wr_ok;

	// Second phase of a transfer
	assign access = psel & penable;

	assign hit_variant = (paddr == `CAB_REG_VARIANT);
	assign hit_dip0    = (paddr == `CAB_REG_DIP0);
	assign hit_dip1    = (paddr == `CAB_REG_DIP1);
	assign hit_spin    = (paddr == `CAB_REG_SPIN);
	assign mapped      = hit_variant | hit_dip0 | hit_dip1 | hit_spin;

	// Spin is read only, so a write there is an error like an unmapped access
	assign pslverr = access & (~mapped | (pwrite & hit_spin));
	assign pready  = 1'b1;

	assign wr_ok = access & pwrite & ~pslverr;

	// ====================
	// Registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			variant <= VAR_BAR;
			dip0    <= `CAB_DIP_RST;
			dip1    <= `CAB_DIP_RST;
		end else if (wr_ok) begin
			if (hit_variant) begin
				variant <= variant_t'(pwdata[1:0]);
			end
			if (hit_dip0) begin
				dip0 <= pwdata[`CAB_PORT_W-1:0];
			end
			if (hit_dip1) begin
				dip1 <= pwdata[`CAB_PORT_W-1:0];
			end
		end
	end

	// ====================
	// Read data
	// ====================

	// Spin is returned live, no snapshot
	always_comb begin
		prdata = '0;
		if (hit_variant) begin
			prdata[1:0] = variant;
		end else if (hit_dip0) begin
			prdata[`CAB_PORT_W-1:0] = dip0;
		end else if (hit_dip1) begin
			prdata[`CAB_PORT_W-1:0] = dip1;
		end else if (hit_spin) begin
			prdata[`CAB_SPIN_W-1:0] = spin;
		end
	end

endmodule

//--- hw/input_port_mux.sv
// Registered CPU input bytes, one cycle behind their sources; start1/start2 come from player 1/2
`timescale 1ns/1ns
`include "cabinet_cfg.svh"

module input_port_mux
	import cabinet_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  joy_word_t  player1,
	input  joy_word_t  player2,
	input  variant_t   variant,
	input  port_byte_t dip0,
	input  port_byte_t dip1,
	input  spin_t      spin,
	output port_byte_t input_0,
	output port_byte_t input_1,
	output port_byte_t input_2,
	output port_byte_t input_3,
	output logic       landscape
);

	// ====================
	// Shared controls
	// ====================
	joy_word_t  joy_m;
	logic       service;
	logic       start1;
	logic       start2;
	logic       coin_m;

	// Positive-logic bytes before inversion
	port_byte_t b0;
	port_byte_t b1;
	port_byte_t b2;
	logic       land_d;

	assign joy_m   = player1 | player2;
	assign service = dip1[0];
	assign start1  = player1[JOY_START];
	assign start2  = player2[JOY_START];

	// Disc game has no coin input of its own, start doubles as coin
	assign coin_m = joy_m[JOY_COIN] | ((variant == VAR_DISC) & (start1 | start2));

	// ====================
	// Per-variant layout
	// ====================
	always_comb begin
		b0     = '0;
		b1     = '0;
		b2     = '0;
		land_d = 1'b1;
		case (variant)
			VAR_BAR: begin
				b0 = {service, 3'b000, start2, start1, 1'b0, coin_m};
				b1 = {3'b000, joy_m[JOY_FIRE_A], joy_m[JOY_UP], joy_m[JOY_DOWN],
					joy_m[JOY_LEFT], joy_m[JOY_RIGHT]};
				b2 = b1;
			end
			VAR_LUMBER: begin
				// Each player has a port of its own here
				b0 = {service, 3'b000, start2, start1, 1'b0, coin_m};
				b1 = {2'b00, player1[JOY_FIRE_A], player1[JOY_FIRE_B], player1[JOY_UP],
					player1[JOY_DOWN], player1[JOY_LEFT], player1[JOY_RIGHT]};
				b2 = {2'b00, player2[JOY_FIRE_A], player2[JOY_FIRE_B], player2[JOY_UP],
					player2[JOY_DOWN], player2[JOY_LEFT], player2[JOY_RIGHT]};
			end
			VAR_DISC: begin
				b0 = {service, 2'b00, joy_m[JOY_FIRE_A], start2, start1, 1'b0, coin_m};
				// Spinner LSB is dropped
				b1 = {1'b0, spin[`CAB_SPIN_W-1:1]};
				b2 = {1'b0, joy_m[JOY_FIRE_B], joy_m[JOY_FIRE_C], joy_m[JOY_FIRE_D],
					joy_m[JOY_DOWN], joy_m[JOY_UP], joy_m[JOY_RIGHT], joy_m[JOY_LEFT]};
			end
			VAR_BAND: begin
				b0 = {service, 2'b00, joy_m[JOY_FIRE_A], start2, start1, 1'b0, coin_m};
				b1 = {4'b0000, joy_m[JOY_DOWN], joy_m[JOY_UP], joy_m[JOY_RIGHT],
					joy_m[JOY_LEFT]};
				b2 = {3'b000, joy_m[JOY_FIRE_A], joy_m[JOY_DOWN], joy_m[JOY_UP],
					joy_m[JOY_RIGHT], joy_m[JOY_LEFT]};
				// Band game runs on a portrait monitor
				land_d = 1'b0;
			end
		endcase
	end

	// ====================
	// Output registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			input_0   <= '1;
			input_1   <= '1;
			input_2   <= '1;
			input_3   <= `CAB_DIP_RST;
			landscape <= 1'b1;
		end else begin
			input_0   <= ~b0;
			input_1   <= ~b1;
			input_2   <= ~b2;
			// DIP byte is already active low
			input_3   <= dip0;
			landscape <= land_d;
		end
	end

endmodule

//--- hw/spinner_counter.sv
// Rotary position from the rotate buttons only; strobe must be low for one cycle between frames
`timescale 1ns/1ns
`include "cabinet_cfg.svh"

module spinner_counter
	import cabinet_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst,
	input  joy_word_t player1,
	input  joy_word_t player2,
	input  logic      vsync_strobe,
	output spin_t     spin
);

	localparam spin_t SPIN_STEP = spin_t'(`CAB_SPIN_STEP);

	logic strobe_q;
	logic strobe_rise;
	logic rot_cw;
	logic rot_ccw;

	// Either player may turn the knob
	assign rot_cw  = player1[JOY_RCW] | player2[JOY_RCW];
	assign rot_ccw = player1[JOY_RCCW] | player2[JOY_RCCW];

	assign strobe_rise = vsync_strobe & ~strobe_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= vsync_strobe;
		end
	end

	// ====================
	// Position
	// ====================

	// Both directions at once cancel out; wraps modulo 2**CAB_SPIN_W
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			spin <= '0;
		end else if (strobe_rise) begin
			if (rot_cw && !rot_ccw) begin
				spin <= spin + SPIN_STEP;
			end else if (rot_ccw && !rot_cw) begin
				spin <= spin - SPIN_STEP;
			end
		end
	end

endmodule

//--- include/cabinet_cfg.svh
// Widths, APB map and variant codes; register map assumes word-aligned 8-bit addresses only
`ifndef CABINET_CFG_SVH
`define CABINET_CFG_SVH

// Data widths
`define CAB_PORT_W      8
`define CAB_JOY_W       12
`define CAB_SPIN_W      8
`define CAB_SPIN_STEP   5
`define CAB_ADDR_W      8

// APB register map
`define CAB_REG_VARIANT 8'h00
`define CAB_REG_DIP0    8'h04
`define CAB_REG_DIP1    8'h08
`define CAB_REG_SPIN    8'h0C

// DIP bytes come out of reset with all switches open
`define CAB_DIP_RST     8'hFF

// Game variant codes
`define CAB_VAR_BAR     2'd0
`define CAB_VAR_LUMBER  2'd1
`define CAB_VAR_DISC    2'd2
`define CAB_VAR_BAND    2'd3

`endif

//--- tests/cabinet_props.sv
// Bound to the top level; checks run outside reset
`timescale 1ns/1ns
`include "cabinet_cfg.svh"

module cabinet_props
	import cabinet_pkg::*;
(
	input logic                   clk_sys,
	input logic                   rst,
	input logic                   psel,
	input logic                   penable,
	input logic                   pwrite,
	input logic [`CAB_ADDR_W-1:0] paddr,
	input logic [31:0]            pwdata,
	input logic                   pslverr,
	input variant_t               variant,
	input port_byte_t             dip0,
	input port_byte_t             dip1,
	input logic                   vsync_strobe,
	input spin_t                  spin
);

	// Settings move only at the end of an error-free write
	a_regs_on_write: assert property (@(posedge clk_sys) disable iff (rst)
		(variant != $past(variant) || dip0 != $past(dip0) || dip1 != $past(dip1))
		|-> $past(psel && penable && pwrite && !pslverr))
		else $error("settings changed without an accepted APB write");

	// A DIP write lands at the edge that closes the access cycle
	a_dip0_write: assert property (@(posedge clk_sys) disable iff (rst)
		(psel && penable && pwrite && !pslverr && paddr == `CAB_REG_DIP0)
		|=> (dip0 == $past(pwdata[`CAB_PORT_W-1:0])))
		else $error("DIP0 write did not take effect");

	// Spin moves one edge after a rising strobe
	a_spin_on_strobe: assert property (@(posedge clk_sys) disable iff (rst)
		(spin != $past(spin)) |-> ($past(vsync_strobe) && !$past(vsync_strobe, 2)))
		else $error("spin changed without a strobe rising edge");

endmodule

bind cabinet_io_top cabinet_props props0 (
	.clk_sys      (clk_sys),
	.rst          (rst),
	.psel         (psel),
	.penable      (penable),
	.pwrite       (pwrite),
	.paddr        (paddr),
	.pwdata       (pwdata),
	.pslverr      (pslverr),
	.variant      (variant),
	.dip0         (dip0),
	.dip1         (dip1),
	.vsync_strobe (vsync_strobe),
	.spin         (spin)
);

//--- tests/tb_cabinet_io.sv
// Checks ports one cycle behind their inputs against a model; stops at the first error
`timescale 1ns/1ns
`include "cabinet_cfg.svh"

module tb_cabinet_io
	import cabinet_pkg::*;
;
	localparam int RAND_CYCLES = 40;
	localparam int STIM_CYCLES = 5 + 14 * 3 + 4 * (9 + RAND_CYCLES) + 84 * 3 + 30;
	localparam int WATCHDOG_NS = 2 * STIM_CYCLES * 4 + 200;

	logic clk_sys;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic pready;
	logic pslverr;
	logic vsync_strobe;
	logic landscape;
	logic [`CAB_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic [31:0] rng;
	joy_word_t player1;
	joy_word_t player2;
	port_byte_t input_0;
	port_byte_t input_1;
	port_byte_t input_2;
	port_byte_t input_3;

	// Model state after the last edge, and expected ports after the next one
	variant_t m_variant;
	port_byte_t m_dip0;
	port_byte_t m_dip1;
	spin_t m_spin;
	logic m_strobe_q;
	logic exp_valid;
	logic exp_err;
	logic rot_cw;
	logic rot_ccw;
	logic [32:0] exp_ports;
	logic [31:0] exp_data;

	tb_clock_gen clk0 (.clk_sys(clk_sys), .rst(rst));

	cabinet_io_top dut0 (
		.clk_sys(clk_sys), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .player1(player1), .player2(player2),
		.vsync_strobe(vsync_strobe), .input_0(input_0), .input_1(input_1),
		.input_2(input_2), .input_3(input_3), .landscape(landscape)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Returns {landscape, input_3, input_2, input_1, input_0}
	function automatic logic [32:0] expected_ports(input joy_word_t p1, input joy_word_t p2,
		input variant_t v, input port_byte_t d0, input port_byte_t d1, input spin_t s);
		joy_word_t m;
		port_byte_t b0;
		port_byte_t b1;
		port_byte_t b2;
		logic land;
		m = p1 | p2;
		b0 = '0;
		b1 = '0;
		b2 = '0;
		land = 1'b1;
		b0[7] = d1[0];
		b0[3] = p2[JOY_START];
		b0[2] = p1[JOY_START];
		b0[0] = m[JOY_COIN] | ((v == VAR_DISC) & (p1[JOY_START] | p2[JOY_START]));
		if (v == VAR_DISC || v == VAR_BAND) b0[4] = m[JOY_FIRE_A];
		case (v)
			VAR_BAR: begin
				b1[4:0] = {m[JOY_FIRE_A], m[JOY_UP], m[JOY_DOWN], m[JOY_LEFT], m[JOY_RIGHT]};
				b2 = b1;
			end
			VAR_LUMBER: begin
				b1[5:0] = {p1[JOY_FIRE_A], p1[JOY_FIRE_B], p1[JOY_UP], p1[JOY_DOWN],
					p1[JOY_LEFT], p1[JOY_RIGHT]};
				b2[5:0] = {p2[JOY_FIRE_A], p2[JOY_FIRE_B], p2[JOY_UP], p2[JOY_DOWN],
					p2[JOY_LEFT], p2[JOY_RIGHT]};
			end
			VAR_DISC: begin
				b1[6:0] = s[7:1];
				b2[6:0] = {m[JOY_FIRE_B], m[JOY_FIRE_C], m[JOY_FIRE_D], m[JOY_DOWN],
					m[JOY_UP], m[JOY_RIGHT], m[JOY_LEFT]};
			end
			default: begin
				b1[3:0] = {m[JOY_DOWN], m[JOY_UP], m[JOY_RIGHT], m[JOY_LEFT]};
				b2[4:0] = {m[JOY_FIRE_A], m[JOY_DOWN], m[JOY_UP], m[JOY_RIGHT], m[JOY_LEFT]};
				land = 1'b0;
			end
		endcase
		return {land, d0, ~b2, ~b1, ~b0};
	endfunction

	task automatic report_failure();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input port_byte_t got, input port_byte_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_spin(input spin_t got, input spin_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: spin got %h expected %h", $time, got, exp);
			report_failure();
		end
	endtask

	task automatic check_apb(input logic [31:0] got_data, input logic [31:0] exp_d,
		input logic got_err, input logic exp_e, input logic is_read);
		check_flag("pslverr", got_err, exp_e);
		if (is_read && !exp_e && got_data !== exp_d) begin
			$display("mismatch at %0t ns: prdata got %h expected %h", $time, got_data, exp_d);
			report_failure();
		end
	endtask

	// ====================
	// Compare process
	// ====================
	always @(negedge clk_sys) begin
		if (exp_valid) begin
			check_byte("input_0", input_0, exp_ports[7:0]);
			check_byte("input_1", input_1, exp_ports[15:8]);
			check_byte("input_2", input_2, exp_ports[23:16]);
			check_byte("input_3", input_3, exp_ports[31:24]);
			check_flag("landscape", landscape, exp_ports[32]);
			check_spin(dut0.spin, m_spin);
		end
		exp_err = !(paddr == `CAB_REG_VARIANT || paddr == `CAB_REG_DIP0
			|| paddr == `CAB_REG_DIP1 || paddr == `CAB_REG_SPIN)
			|| (pwrite && paddr == `CAB_REG_SPIN);
		exp_data = '0;
		if (paddr == `CAB_REG_VARIANT) exp_data[1:0] = m_variant;
		else if (paddr == `CAB_REG_DIP0) exp_data[7:0] = m_dip0;
		else if (paddr == `CAB_REG_DIP1) exp_data[7:0] = m_dip1;
		else if (paddr == `CAB_REG_SPIN) exp_data[7:0] = m_spin;
		if (!rst && psel && penable) check_apb(prdata, exp_data, pslverr, exp_err, !pwrite);
		else if (exp_valid) check_flag("pslverr", pslverr, 1'b0);
		if (rst) begin
			m_variant = VAR_BAR;
			m_dip0 = 8'hFF;
			m_dip1 = 8'hFF;
			m_spin = '0;
			m_strobe_q = 1'b0;
			exp_ports = {1'b1, 8'hFF, 8'hFF, 8'hFF, 8'hFF};
		end else begin
			exp_ports = expected_ports(player1, player2, m_variant, m_dip0, m_dip1, m_spin);
			if (psel && penable && pwrite && !exp_err) begin
				if (paddr == `CAB_REG_VARIANT) m_variant = variant_t'(pwdata[1:0]);
				if (paddr == `CAB_REG_DIP0) m_dip0 = pwdata[7:0];
				if (paddr == `CAB_REG_DIP1) m_dip1 = pwdata[7:0];
			end
			rot_cw = player1[JOY_RCW] | player2[JOY_RCW];
			rot_ccw = player1[JOY_RCCW] | player2[JOY_RCCW];
			if (vsync_strobe && !m_strobe_q && rot_cw && !rot_ccw) m_spin = m_spin + 8'd5;
			if (vsync_strobe && !m_strobe_q && rot_ccw && !rot_cw) m_spin = m_spin - 8'd5;
			m_strobe_q = vsync_strobe;
		end
		exp_valid = 1'b1;
	end

	// ====================
	// Stimulus
	// ====================
	task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk_sys);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk_sys);
		penable <= 1'b1;
		do @(posedge clk_sys); while (pready !== 1'b1);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic drive_players(input joy_word_t p1, input joy_word_t p2, input logic strobe);
		@(posedge clk_sys);
		player1 <= p1;
		player2 <= p2;
		vsync_strobe <= strobe;
	endtask

	task automatic pulse_strobe(input joy_word_t p1, input joy_word_t p2);
		drive_players(p1, p2, 1'b1);
		drive_players(p1, p2, 1'b0);
		drive_players(p1, p2, 1'b0);
	endtask

	initial begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		player1 = '0;
		player2 = '0;
		vsync_strobe = 1'b0;
		exp_valid = 1'b0;
		rng = 32'h1483;
		wait (rst == 1'b0);
		for (int a = 0; a < 16; a += 4) apb_transfer(1'b0, 8'(a), '0);
		apb_transfer(1'b1, `CAB_REG_VARIANT, 32'h2);
		apb_transfer(1'b1, `CAB_REG_DIP0, 32'h5A);
		apb_transfer(1'b1, `CAB_REG_DIP1, 32'hC3);
		apb_transfer(1'b1, `CAB_REG_SPIN, 32'h77);
		apb_transfer(1'b1, 8'h10, 32'h11);
		apb_transfer(1'b0, 8'h03, '0);
		for (int a = 0; a < 16; a += 4) apb_transfer(1'b0, 8'(a), '0);
		for (int v = 0; v < 4; v++) begin
			apb_transfer(1'b1, `CAB_REG_VARIANT, 32'(v));
			rng = xorshift32(rng);
			apb_transfer(1'b1, `CAB_REG_DIP0, rng);
			apb_transfer(1'b1, `CAB_REG_DIP1, rng >> 8);
			for (int i = 0; i < RAND_CYCLES; i++) begin
				rng = xorshift32(rng);
				drive_players(rng[11:0], rng[27:16], 1'b0);
			end
		end
		// Spinner in the disc game, wrapping both ways
		apb_transfer(1'b1, `CAB_REG_VARIANT, 32'h2);
		drive_players(12'h400, 12'h000, 1'b0);
		drive_players(12'h000, 12'h400, 1'b0);
		for (int i = 0; i < 60; i++) pulse_strobe(12'h100, 12'h000);
		for (int i = 0; i < 14; i++) pulse_strobe(12'h000, 12'h200);
		for (int i = 0; i < 3; i++) pulse_strobe(12'h100, 12'h200);
		drive_players(12'h100, 12'h000, 1'b1);
		repeat (4) drive_players(12'h100, 12'h000, 1'b1);
		drive_players(12'h000, 12'h000, 1'b0);
		apb_transfer(1'b0, `CAB_REG_SPIN, '0);
		repeat (3) drive_players(12'h000, 12'h000, 1'b0);
		$display("SIMULATION PASSED");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the stimulus finished");
		report_failure();
	end

endmodule

//--- tests/tb_clock_gen.sv
// Free-running 4 ns clock; reset is held high for the first 5 rising edges
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		rst = 1'b1;
		repeat (5) @(posedge clk_sys);
		rst <= 1'b0;
	end

	always #2 clk_sys = ~clk_sys;

endmodule
